//--- hw/qspi_pkg.sv
package qspi_pkg;

    // serial clock divider, system cycles per half sck period (1 to 8)
    localparam int SCK_HALF = 2;
    localparam int DIV_W    = 3;

    localparam int BYTE_W = 8;
    localparam int ADDR_W = 24;
    localparam int LEN_W  = 8;
    localparam int IO_W   = 4;

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LEN_W-1:0]  len_t;   // bytes per read, at least 1
    typedef logic [IO_W-1:0]   io_t;    // io3..io0
    typedef logic [DIV_W-1:0]  div_t;

    // flash opcodes
    localparam byte_t OP_READ      = 8'h03;
    localparam byte_t OP_QUAD_READ = 8'h6B;
    localparam byte_t DUMMY_BYTE   = 8'h00;

    // pin bundle from the top level towards the flash
    typedef struct packed {
        logic sck;
        logic cs_n;
        io_t  io_out;
        io_t  io_oe;
    } qspi_pins_t;

endpackage

//--- hw/qspi_byte_engine.sv
`timescale 1ns/1ps

module qspi_byte_engine
    import qspi_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  start_i,
    input  logic  quad_i,
    input  byte_t tx_byte_i,
    input  io_t   io_in_i,
    output byte_t rx_byte_o,
    output logic  busy_o,
    output logic  done_o,
    output logic  sck_o,
    output io_t   io_out_o,
    output io_t   io_oe_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_HIGH,
        S_LOW
    } state_t;

    state_t     state_q;
    div_t       div_q;
    logic [2:0] step_q;     // bit or nibble index
    logic       quad_q;
    logic       done_q;
    byte_t      tx_q;
    byte_t      rx_q;

    logic half_end;
    logic last_step;
    logic rise;
    logic fall;

    assign half_end  = (div_q == div_t'(SCK_HALF - 1));
    assign last_step = quad_q ? (step_q == 3'd1) : (step_q == 3'd7);
    assign rise      = (state_q == S_LOW) && half_end;
    assign fall      = (state_q == S_HIGH) && half_end;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= S_IDLE;
            div_q   <= '0;
            step_q  <= '0;
            quad_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q <= S_LOW;   // sck low for the first half period
                        div_q   <= '0;
                        step_q  <= '0;
                        quad_q  <= quad_i;
                    end
                end
                S_LOW: begin
                    if (half_end) begin
                        state_q <= S_HIGH;
                        div_q   <= '0;
                    end else begin
                        div_q <= div_q + 1'b1;
                    end
                end
                S_HIGH: begin
                    if (half_end) begin
                        div_q <= '0;
                        if (last_step) begin
                            state_q <= S_IDLE;
                            done_q  <= 1'b1;
                        end else begin
                            state_q <= S_LOW;
                            step_q  <= step_q + 1'b1;
                        end
                    end else begin
                        div_q <= div_q + 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // shift registers
    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && start_i) begin
            tx_q <= tx_byte_i;
        end else if (fall) begin
            tx_q <= {tx_q[6:0], 1'b0};  // next bit out on falling sck
        end
        if (rise) begin
            if (quad_q) begin
                rx_q <= {rx_q[3:0], io_in_i};   // high nibble arrives first
            end else begin
                rx_q <= {rx_q[6:0], io_in_i[1]};
            end
        end
    end

    assign sck_o     = (state_q == S_HIGH);
    assign busy_o    = start_i | (state_q != S_IDLE);
    assign done_o    = done_q;
    assign rx_byte_o = rx_q;

    // wp# and hold# held high in single mode, all lines released for quad input
    assign io_out_o = {2'b11, 1'b0, tx_q[7]};
    assign io_oe_o  = (state_q != S_IDLE && !quad_q) ? 4'b1101 : 4'b0000;

    a_no_start_while_busy: assert property (
        @(posedge clk_i) disable iff (rst_i)
        start_i |-> (state_q == S_IDLE)
    );

    // sck parked low out of idle, first rise one half period later
    a_sck_low_from_idle: assert property (
        @(posedge clk_i) disable iff (rst_i)
        start_i |=> !sck_o ##SCK_HALF sck_o
    );

endmodule

//--- hw/flash_read_ctrl.sv
`timescale 1ns/1ps

module flash_read_ctrl
    import qspi_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  req_i,
    input  logic  quad_i,
    input  addr_t addr_i,
    input  len_t  len_i,
    input  logic  eng_busy_i,
    input  logic  eng_done_i,
    input  byte_t eng_rx_i,
    output logic  eng_start_o,
    output logic  eng_quad_o,
    output byte_t eng_tx_o,
    output logic  cs_n_o,
    output byte_t rd_data_o,
    output logic  rd_valid_o,
    output logic  busy_o,
    output logic  done_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CMD,
        S_ADDR,
        S_DUMMY,
        S_DATA,
        S_CLOSE,
        S_DONE
    } state_t;

    state_t     state_q;
    logic       quad_q;
    addr_t      addr_q;     // shifted left as bytes go out
    len_t       rem_q;
    logic [1:0] addr_cnt_q;

    assign busy_o = (state_q != S_IDLE) | eng_busy_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= S_IDLE;
            cs_n_o      <= 1'b1;
            eng_start_o <= 1'b0;
            eng_quad_o  <= 1'b0;
            rd_valid_o  <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            eng_start_o <= 1'b0;
            rd_valid_o  <= 1'b0;
            done_o      <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (req_i && !busy_o) begin
                        quad_q      <= quad_i;
                        addr_q      <= addr_i;
                        rem_q       <= len_i;
                        addr_cnt_q  <= '0;
                        cs_n_o      <= 1'b0;
                        eng_start_o <= 1'b1;
                        eng_quad_o  <= 1'b0;
                        eng_tx_o    <= quad_i ? OP_QUAD_READ : OP_READ;
                        state_q     <= S_CMD;
                    end
                end
                S_CMD, S_ADDR: begin
                    if (eng_done_i) begin
                        eng_start_o <= 1'b1;
                        if (state_q == S_ADDR && addr_cnt_q == 2'd2) begin
                            eng_tx_o <= DUMMY_BYTE;
                            state_q  <= quad_q ? S_DUMMY : S_DATA;
                        end else begin
                            eng_tx_o <= addr_q[23:16];  // msb first
                            addr_q   <= {addr_q[15:0], 8'h00};
                            if (state_q == S_ADDR) begin
                                addr_cnt_q <= addr_cnt_q + 1'b1;
                            end
                            state_q <= S_ADDR;
                        end
                    end
                end
                S_DUMMY: begin
                    if (eng_done_i) begin
                        eng_start_o <= 1'b1;
                        eng_quad_o  <= 1'b1;    // data phase on all four lines
                        eng_tx_o    <= DUMMY_BYTE;
                        state_q     <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (eng_done_i) begin
                        rd_data_o  <= eng_rx_i;
                        rd_valid_o <= 1'b1;
                        rem_q      <= rem_q - 1'b1;
                        if (rem_q == len_t'(1)) begin
                            state_q <= S_CLOSE;
                        end else begin
                            eng_start_o <= 1'b1;
                            eng_tx_o    <= DUMMY_BYTE;
                        end
                    end
                end
                S_CLOSE: begin
                    cs_n_o     <= 1'b1;
                    eng_quad_o <= 1'b0;
                    state_q    <= S_DONE;
                end
                S_DONE: begin
                    done_o  <= 1'b1;    // one cycle after cs_n rises
                    state_q <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    a_valid_inside_cs: assert property (
        @(posedge clk_i) disable iff (rst_i)
        rd_valid_o |-> !cs_n_o
    );

endmodule

//--- hw/qspi_flash_top.sv
`timescale 1ns/1ps

module qspi_flash_top
    import qspi_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       req_i,
    input  logic       quad_i,
    input  addr_t      addr_i,
    input  len_t       len_i,
    input  io_t        io_in_i,
    output byte_t      rd_data_o,
    output logic       rd_valid_o,
    output logic       busy_o,
    output logic       done_o,
    output qspi_pins_t pins_o
);

    logic  eng_start;
    logic  eng_quad;
    byte_t eng_tx;
    byte_t eng_rx;
    logic  eng_busy;
    logic  eng_done;
    logic  sck;
    logic  cs_n;
    io_t   io_out;
    io_t   io_oe;

    flash_read_ctrl i_flash_read_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .quad_i      (quad_i),
        .addr_i      (addr_i),
        .len_i       (len_i),
        .eng_busy_i  (eng_busy),
        .eng_done_i  (eng_done),
        .eng_rx_i    (eng_rx),
        .eng_start_o (eng_start),
        .eng_quad_o  (eng_quad),
        .eng_tx_o    (eng_tx),
        .cs_n_o      (cs_n),
        .rd_data_o   (rd_data_o),
        .rd_valid_o  (rd_valid_o),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    qspi_byte_engine i_qspi_byte_engine (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .start_i   (eng_start),
        .quad_i    (eng_quad),
        .tx_byte_i (eng_tx),
        .io_in_i   (io_in_i),
        .rx_byte_o (eng_rx),
        .busy_o    (eng_busy),
        .done_o    (eng_done),
        .sck_o     (sck),
        .io_out_o  (io_out),
        .io_oe_o   (io_oe)
    );

    assign pins_o.sck    = sck;
    assign pins_o.cs_n   = cs_n;
    assign pins_o.io_out = io_out;
    assign pins_o.io_oe  = io_oe;

endmodule

//--- tb/flash_model.sv
`timescale 1ns/1ps

module flash_model
    import qspi_pkg::*;
(
    input  qspi_pins_t pins_i,
    output io_t        io_o,
    output byte_t      opcode_o,
    output addr_t      addr_o,
    output int         edges_o
);

    logic  sck;
    logic  cs_n;
    logic  sck_prev = 1'b0;
    logic  cs_prev  = 1'b1;
    int    edge_cnt = 0;    // sck rising edges since cs_n fell
    int    edges_q  = 0;
    int    idx      = 0;
    io_t   io_q     = 4'hF;
    byte_t op_sr    = '0;
    byte_t op_q     = '0;
    addr_t addr_sr  = '0;
    addr_t addr_q   = '0;
    byte_t cur      = '0;

    assign sck      = pins_i.sck;
    assign cs_n     = pins_i.cs_n;
    assign io_o     = io_q;
    assign opcode_o = op_q;
    assign addr_o   = addr_q;
    assign edges_o  = edges_q;

    // array content, low byte of a*7+3
    function automatic byte_t mem_byte(input addr_t a);
        logic [31:0] prod;
        prod = {8'h00, a} * 32'd7 + 32'd3;
        return prod[7:0];
    endfunction

    always @(sck or cs_n) begin
        if (cs_n != cs_prev) begin
            if (!cs_n) begin
                edge_cnt = 0;
                io_q     = 4'hF;
            end else begin
                edges_q = edge_cnt;
            end
        end else if (!cs_n && sck && !sck_prev) begin
            if (edge_cnt < 8) begin
                op_sr = {op_sr[6:0], pins_i.io_out[0]};
            end else if (edge_cnt < 32) begin
                addr_sr = {addr_sr[22:0], pins_i.io_out[0]};    // msb first
            end
            edge_cnt++;
            if (edge_cnt == 8) op_q = op_sr;
            if (edge_cnt == 32) addr_q = addr_sr;
        end else if (!cs_n && !sck && sck_prev) begin
            // data changes on the falling edge, host samples on the next rise
            if (op_q == OP_READ && edge_cnt >= 32) begin
                idx     = edge_cnt - 32;
                cur     = mem_byte(addr_q + addr_t'(idx / 8));
                io_q[1] = cur[7 - (idx % 8)];
            end else if (op_q == OP_QUAD_READ && edge_cnt >= 40) begin
                idx  = edge_cnt - 40;   // eight dummy clocks first
                cur  = mem_byte(addr_q + addr_t'(idx / 2));
                io_q = (idx % 2 == 0) ? cur[7:4] : cur[3:0];
            end
        end
        cs_prev  = cs_n;
        sck_prev = sck;
    end

endmodule

//--- tb/tb_qspi_flash.sv
`timescale 1ns/1ps

module tb_qspi_flash
    import qspi_pkg::*;
();

    localparam int REC_W    = 8;    // words per test data line
    localparam int MAX_RECS = 24;
    localparam int TIMEOUT  = 5000; // cycles per read

    logic        clk;
    logic        rst;
    logic        req;
    logic        quad;
    addr_t       addr;
    len_t        len;
    io_t         io_in;
    byte_t       rd_data;
    logic        rd_valid;
    logic        busy;
    logic        done;
    qspi_pins_t  pins;
    byte_t       model_op;
    addr_t       model_addr;
    int          model_edges;
    logic [23:0] tdata [0:REC_W*MAX_RECS-1];
    int          err_cnt;
    int          fail_cnt;
    logic        timed_out;

    qspi_flash_top i_qspi_flash_top (
        .clk_i      (clk),
        .rst_i      (rst),
        .req_i      (req),
        .quad_i     (quad),
        .addr_i     (addr),
        .len_i      (len),
        .io_in_i    (io_in),
        .rd_data_o  (rd_data),
        .rd_valid_o (rd_valid),
        .busy_o     (busy),
        .done_o     (done),
        .pins_o     (pins)
    );

    flash_model i_flash_model (
        .pins_i   (pins),
        .io_o     (io_in),
        .opcode_o (model_op),
        .addr_o   (model_addr),
        .edges_o  (model_edges)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic byte_t rule_byte(input addr_t a);
        logic [31:0] prod;
        prod = {8'h00, a} * 32'd7 + 32'd3;
        return prod[7:0];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic drive(input logic r, input logic q, input addr_t a, input len_t n);
        req  = r;
        quad = q;
        addr = a;
        len  = n;
    endtask

    // port quiet, no transfer in progress
    task automatic idle_check(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check("cs_n", 32'(pins.cs_n), 32'd1);
            check("io_oe", 32'(pins.io_oe), 32'd0);
            check("sck", 32'(pins.sck), 32'd0);
            check("rd_valid_o", 32'(rd_valid), 32'd0);
            check("done_o", 32'(done), 32'd0);
            check("busy_o", 32'(busy), 32'd0);
        end
    endtask

    task automatic report(input int id, input string what, input int errs_before);
        if (err_cnt == errs_before && !timed_out) begin
            $display("test %0d, %s, ok", id, what);
        end else begin
            $display("test %0d, %s, failed with %0d errors", id, what, err_cnt - errs_before);
            fail_cnt++;
        end
    endtask

    task automatic run_read(input int id, input int base);
        logic  mode;
        logic  kind;
        addr_t a;
        len_t  n;
        byte_t exp;
        int    nvalid;
        int    cyc;
        int    errs_before;
        logic  seen_done;

        mode        = tdata[base][0];
        kind        = tdata[base+1][0];
        a           = tdata[base+2];
        n           = tdata[base+3][7:0];
        errs_before = err_cnt;
        nvalid      = 0;
        cyc         = 0;
        seen_done   = 1'b0;
        @(posedge clk);
        #1;
        drive(1'b1, mode, a, n);
        while (!seen_done && cyc < TIMEOUT) begin
            @(posedge clk);
            #1;
            if (kind && cyc == 20) begin
                check("busy_o", 32'(busy), 32'd1);
                drive(1'b1, ~mode, a ^ 24'h000800, n + 8'd5);   // must be ignored
            end else begin
                drive(1'b0, 1'b0, '0, '0);
            end
            @(negedge clk);
            if (rd_valid) begin
                exp = (nvalid < 4) ? tdata[base+4+nvalid][7:0] : rule_byte(a + addr_t'(nvalid));
                check("rd_data_o", 32'(rd_data), 32'(exp));
                nvalid++;
            end
            if (nvalid < int'(n)) begin
                check("cs_n", 32'(pins.cs_n), 32'd0);
            end
            seen_done = done;
            cyc++;
        end
        if (!seen_done) begin
            $display("timeout, test %0d saw no done_o pulse within %0d cycles", id, TIMEOUT);
            timed_out = 1'b1;
        end else begin
            check("rd_valid_o count", 32'(nvalid), 32'(n));
            check("cs_n", 32'(pins.cs_n), 32'd1);
            check("flash opcode", 32'(model_op), mode ? 32'h6B : 32'h03);
            check("flash address", 32'(model_addr), 32'(a));
            // 8 command and 24 address clocks, quad adds one dummy byte
            check("sck rising edges", 32'(model_edges),
                  mode ? 32'(40 + 2 * int'(n)) : 32'(32 + 8 * int'(n)));
            idle_check(20);
        end
        report(id, $sformatf("%s read at %06h of %0d bytes", mode ? "quad" : "single", a, n),
               errs_before);
    endtask

    initial begin
        int rec;
        int errs_before;

        rst = 1'b1;
        drive(1'b0, 1'b0, '0, '0);
        err_cnt   = 0;
        fail_cnt  = 0;
        timed_out = 1'b0;
        rec       = 0;
        $readmemh("tb/qspi_testdata.txt", tdata);
        repeat (16) @(posedge clk);
        #1;
        rst         = 1'b0;
        errs_before = err_cnt;
        idle_check(30);
        report(0, "idle after reset", errs_before);
        while (rec < MAX_RECS && tdata[rec*REC_W] != 24'h00000F && !timed_out) begin
            run_read(rec + 1, rec * REC_W);
            rec++;
        end
        if (rec == MAX_RECS) begin
            $display("test data has no end marker line");
            err_cnt++;
        end
        $display("%0d tests run, %0d failed, %0d errors", rec + 1, fail_cnt, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tb/qspi_testdata.txt
// columns in hex: mode kind addr len b0 b1 b2 b3 (mode 0 single, 1 quad, f ends the list)
// kind 1 sends a second request while busy; byte columns past len are 00
0 0 000010 01 73 00 00 00
1 0 000100 04 03 0a 11 18
0 0 123456 14 5d 64 6b 72
1 0 123456 14 5d 64 6b 72
0 0 fffffe 04 f5 fc 03 0a
1 0 fffffe 04 f5 fc 03 0a
0 1 000042 03 d1 d8 df 00
1 1 0000a0 02 63 6a 00 00
0 0 abcdef 01 8c 00 00 00
1 0 000000 01 03 00 00 00
0 0 0000ff 02 fc 03 00 00
1 0 0000fe 03 f5 fc 03 00
f 0 000000 00 00 00 00 00

//--- files.f
hw/qspi_pkg.sv
hw/qspi_byte_engine.sv
hw/flash_read_ctrl.sv
hw/qspi_flash_top.sv
tb/flash_model.sv
tb/tb_qspi_flash.sv

//--- Makefile
# Verilator build and run of the serial flash read port

VERILATOR ?= verilator
TOP       ?= tb_qspi_flash
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FAIL_MSG  := TEST RESULT: FAIL

.PHONY: help test clean

help:
	@echo "targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS can be overridden"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
